// ==== Bender.yml ====
package:
  name: fp_add

sources:
  # synthesizable adder, package first
  - files:
      - verilog/fp_add_pkg.sv
      - verilog/fp_align.sv
      - verilog/fp_addsub_norm.sv
      - verilog/fp_rounding.sv
      - verilog/fp_round_pack.sv
      - verilog/fp_add_top.sv
  # testbench and bound assertions
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fp_add_assertions.sv
      - verif/fp_add_tb.sv

// ==== all.f ====
+incdir+verif
verilog/fp_add_pkg.sv
verilog/fp_align.sv
verilog/fp_addsub_norm.sv
verilog/fp_rounding.sv
verilog/fp_round_pack.sv
verilog/fp_add_top.sv
verif/fp_add_assertions.sv
verif/fp_add_tb.sv

// ==== verif/fp_add_assertions.sv ====
`timescale 1ns/1ns

module fp_add_assertions (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  valid_i,
    input fp_add_pkg::rnd_mode_t rnd_mode_i,
    input logic                  valid_o
);

    int err_count = 0; // failed assertions so far

    // no result strobe while in reset
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
        else begin
            err_count++;
            $error("valid_o high during reset");
        end

    // three stages, every strobe comes out
    latency_fwd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> ##3 valid_o)
        else begin
            err_count++;
            $error("valid_o missing 3 cycles after valid_i");
        end

    // and nothing comes out without a strobe
    latency_back: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> $past(valid_i, 3))
        else begin
            err_count++;
            $error("valid_o without valid_i 3 cycles earlier");
        end

    legal_mode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> (rnd_mode_i <= fp_add_pkg::FRM_RMM)) // codes 5..7 reserved
        else begin
            err_count++;
            $error("illegal rounding mode with valid_i");
        end

endmodule

bind fp_add_top fp_add_assertions i_assertions (.*);

// ==== verif/fp_add_model.svh ====
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// round-up decision from the lsb, round and sticky bits
function automatic logic mode_rounds_up(input logic [2:0] mode, input logic sign,
                                        input logic lsb, input logic rnd, input logic stk);
    case (mode)
        fp_add_pkg::FRM_RNE: return rnd && (stk || lsb);  // ties go to the even one
        fp_add_pkg::FRM_RDN: return (rnd || stk) && sign;
        fp_add_pkg::FRM_RUP: return (rnd || stk) && !sign;
        fp_add_pkg::FRM_RMM: return rnd;                  // ties away from zero
        default:             return 1'b0;                 // rtz truncates
    endcase
endfunction

// expected {status, result} of a + b, or a - b with sub set
function automatic logic [35:0] expected_add(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub, input logic [2:0] mode);
    logic         sa;
    logic         sb;          // b sign after the subtract flip
    logic         eff_sub;
    logic         nan_a;
    logic         nan_b;
    logic         inf_a;
    logic         inf_b;
    logic [299:0] grid_a;      // value = grid * 2^-149
    logic [299:0] grid_b;
    logic [299:0] mag;
    logic [299:0] norm;
    logic         rs;          // sign of the exact sum
    int           p;
    int           e;
    logic [22:0]  frac;
    logic         rnd;
    logic         stk;
    logic [24:0]  man;
    logic [3:0]   st;
    sa      = a[31];
    sb      = b[31] ^ sub;
    eff_sub = sa ^ sb;
    nan_a   = (a[30:23] == 8'hff) && (a[22:0] != '0);
    nan_b   = (b[30:23] == 8'hff) && (b[22:0] != '0);
    inf_a   = (a[30:23] == 8'hff) && (a[22:0] == '0);
    inf_b   = (b[30:23] == 8'hff) && (b[22:0] == '0);
    st      = '0;
    if (nan_a || nan_b) begin
        st[fp_add_pkg::ST_NV] = (nan_a && !a[22]) || (nan_b && !b[22]); // signaling only
        return {st, fp_add_pkg::FP_QNAN};
    end
    if (inf_a && inf_b && eff_sub) begin
        st[fp_add_pkg::ST_NV] = 1'b1; // inf - inf
        return {st, fp_add_pkg::FP_QNAN};
    end
    if (inf_a)
        return {4'd0, sa, 8'hff, 23'd0};
    if (inf_b)
        return {4'd0, sb, 8'hff, 23'd0};
    // zero exponent reads as signed zero, subnormals too
    grid_a = (a[30:23] == '0) ? '0 : (300'({1'b1, a[22:0]}) << (a[30:23] - 8'd1));
    grid_b = (b[30:23] == '0) ? '0 : (300'({1'b1, b[22:0]}) << (b[30:23] - 8'd1));
    if (!eff_sub) begin
        mag = grid_a + grid_b;
        rs  = sa;
    end else if (grid_a >= grid_b) begin
        mag = grid_a - grid_b;
        rs  = sa;
    end else begin
        mag = grid_b - grid_a;
        rs  = sb;
    end
    if (mag == '0)
        return {4'd0, eff_sub ? (mode == fp_add_pkg::FRM_RDN) : sa, 31'd0};
    p = 0;
    for (int i = 0; i < 300; i++) begin
        if (mag[i])
            p = i; // leading one
    end
    norm = mag << (299 - p);
    e    = p - 22;          // biased exponent before rounding
    frac = norm[298:276];
    rnd  = norm[275];
    stk  = |norm[274:0];
    if (e <= 0) begin
        st[fp_add_pkg::ST_UF] = 1'b1;
        st[fp_add_pkg::ST_NX] = 1'b1;
        return {st, rs, 31'd0}; // flushed
    end
    man = {2'b01, frac} + 25'(mode_rounds_up(mode, rs, frac[0], rnd, stk));
    if (man[24])
        e = e + 1;              // rounded up to the next binade
    frac = man[24] ? man[23:1] : man[22:0];
    if (e >= 255) begin
        st[fp_add_pkg::ST_OF] = 1'b1;
        st[fp_add_pkg::ST_NX] = 1'b1;
        if (mode == fp_add_pkg::FRM_RNE || mode == fp_add_pkg::FRM_RMM ||
            (mode == fp_add_pkg::FRM_RUP && !rs) || (mode == fp_add_pkg::FRM_RDN && rs))
            return {st, rs, 8'hff, 23'd0};
        return {st, rs, 8'hfe, 23'h7f_ffff}; // largest finite
    end
    st[fp_add_pkg::ST_NX] = rnd || stk;
    return {st, rs, e[7:0], frac};
endfunction

`endif

// ==== verif/fp_add_tb.sv ====
`timescale 1ns/1ns

module fp_add_tb;

    `include "fp_add_model.svh"

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  valid;
    fp_add_pkg::fp32_t     a;
    fp_add_pkg::fp32_t     b;
    logic                  sub;
    fp_add_pkg::rnd_mode_t rnd_mode;
    logic                  valid_out;
    fp_add_pkg::fp32_t     result;
    fp_add_pkg::status_t   status;

    integer      seed = 80;
    int          cycle = 0;       // rising edges so far
    int          value_errs = 0;
    int          proto_errs = 0;
    int          n_in = 0;
    int          n_out = 0;
    logic [35:0] exp_q[$];        // {status, result} in issue order
    int          issue_q[$];      // cycle of each strobe
    string       name_q[$];

    fp_add_top i_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .valid_i    (valid),
        .a_i        (a),
        .b_i        (b),
        .sub_i      (sub),
        .rnd_mode_i (rnd_mode),
        .valid_o    (valid_out),
        .result_o   (result),
        .status_o   (status)
    );

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // operand pair from one of the stimulus classes
    task automatic pick_operands(input logic s, output logic [31:0] x, output logic [31:0] y,
                                 output string tag);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] t;
        r1  = $random(seed);
        r2  = $random(seed);
        x   = {r1[31], 8'(27 + rand_below(228)), r1[22:0]}; // normals, exp 27..254
        y   = {r2[31], 8'(27 + rand_below(228)), r2[22:0]};
        tag = "normal";
        case (rand_below(10))
            3: begin
                y   = {r2[31], x[30:0] + 31'(r2[7:4] % 9) - 31'd4}; // within 4 ulps
                tag = "near_equal";
            end
            4: begin
                x[30:23] = 8'(60 + rand_below(195));
                y[30:23] = x[30:23] - 8'(27 + rand_below(30)); // shifted out entirely
                tag      = "exp_gap";
            end
            5: begin
                y   = {r2[31], 8'd0, r2[0] ? r2[22:0] : 23'd0}; // zero or subnormal
                x   = r1[0] ? {r1[31], 31'd0} : x;
                tag = "zero_subnormal";
            end
            6: begin
                case (rand_below(3))
                    0:       y = {r2[31], 8'hff, 23'd0};
                    1:       y = {r2[31], 8'hff, 1'b1, r2[21:0]};        // quiet
                    default: y = {r2[31], 8'hff, 1'b0, r2[21:1], 1'b1}; // signaling
                endcase
                x   = r1[0] ? {r1[31], 8'hff, 23'd0} : x;
                tag = "inf_nan";
            end
            7: begin
                x[30:20] = {8'(250 + rand_below(5)), 3'b111};
                y[30:23] = 8'(250 + rand_below(5));
                tag      = "near_max";
            end
            8: begin
                y   = {r2[31], x[30:23] - 8'd24, 23'd0}; // exactly half an ulp of x
                tag = "tie";
            end
            9: begin
                if (r1[1]) begin
                    y   = {x[31] ^ s ^ 1'b1, x[30:0]}; // x - x
                    tag = "cancel";
                end else begin
                    // smallest exponent on both, difference 2^-127 or a power below
                    t   = 23'h40_0000 + (r1[3] ? 23'(r1[20:0]) : 23'd0);
                    y   = {x[31] ^ s ^ 1'b1, 8'd1, 2'b00, r2[20:0]};
                    x   = {x[31], 8'd1, 23'(r2[20:0]) + 23'(t >> rand_below(23))};
                    tag = "underflow";
                end
            end
            default: ;
        endcase
        if (r1[2]) begin // larger operand on either side
            t = x;
            x = y;
            y = t;
        end
    endtask

    // one strobe, expected value goes to the scoreboard
    task automatic issue_op();
        logic [31:0] x;
        logic [31:0] y;
        logic        s;
        logic [2:0]  m;
        string       tag;
        s = 1'(rand_below(2));
        m = 3'(rand_below(5));
        pick_operands(s, x, y, tag);
        valid    = 1'b1;
        a        = x;
        b        = y;
        sub      = s;
        rnd_mode = m;
        exp_q.push_back(expected_add(x, y, s, m));
        issue_q.push_back(cycle);
        name_q.push_back(tag);
        n_in++;
    endtask

    always @(negedge clk) begin : check_outputs
        logic [35:0] expv;
        int          issued;
        string       tag;
        if (valid_out) begin
            n_out++;
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("valid_o arrived with no operation outstanding");
            end
            if (exp_q.size() != 0) begin
                expv   = exp_q.pop_front();
                issued = issue_q.pop_front();
                tag    = name_q.pop_front();
                assert (result == expv[31:0]) else begin
                    value_errs++;
                    $display("[FAIL] %s result: expected %h, actual %h", tag, expv[31:0], result);
                end
                assert (status == expv[35:32]) else begin
                    value_errs++;
                    $display("[FAIL] %s flags: expected %b, actual %b", tag, expv[35:32], status);
                end
                assert (cycle == issued + 3) else begin
                    value_errs++;
                    $display("[FAIL] %s latency: expected %0d, actual %0d", tag, 3, cycle - issued);
                end
            end
        end
    end

    initial begin
        int unsigned len;
        int          sva_errs;
        valid    = 1'b0;
        a        = '0;
        b        = '0;
        sub      = 1'b0;
        rnd_mode = fp_add_pkg::FRM_RNE;
        rst_n    = 1'b0;
        for (int i = 0; i < 2; i++) begin // two cycles in reset
            @(negedge clk);
            assert (!valid_out) else begin
                proto_errs++;
                $display("valid_o went high during reset");
            end
        end
        rst_n = 1'b1;
        assert (result == '0 && status == '0) else begin
            proto_errs++;
            $display("outputs are not zero after reset");
        end
        for (int g = 0; g < 1500; g++) begin
            len = (rand_below(10) < 6) ? 1 : 2 + rand_below(7); // single or burst
            for (int k = 0; k < len; k++) begin
                issue_op();
                @(negedge clk);
            end
            valid = 1'b0;
            repeat (rand_below(3)) @(negedge clk);
        end
        valid = 1'b0;
        for (int t = 0; t < 10 && exp_q.size() > 0; t++)
            @(negedge clk); // drain the pipe
        assert (exp_q.size() == 0) else begin
            proto_errs++;
            $display("%0d operations never completed", exp_q.size());
        end
        assert (n_out == n_in) else begin
            proto_errs++;
            $display("%0d strobes in but %0d results out", n_in, n_out);
        end
        sva_errs = i_dut.i_assertions.err_count;
        $display("ops %0d, value errors %0d, protocol errors %0d, assertion errors %0d",
                 n_in, value_errs, proto_errs, sva_errs);
        if (value_errs + proto_errs + sva_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog/fp_add_pkg.sv ====
package fp_add_pkg;

    // binary32 fields
    typedef logic [31:0] fp32_t;   // sign, exponent, fraction
    typedef logic [7:0]  fp_exp_t; // biased exponent
    typedef logic [23:0] fp_man_t; // significand incl. hidden bit
    typedef logic [30:0] fp_abs_t; // {exponent, fraction}, rounding carry ripples into exp

    typedef logic [2:0] rnd_mode_t; // RISC-V frm encoding
    typedef logic [3:0] status_t;   // {NV, OF, UF, NX}

    // rounding modes
    localparam rnd_mode_t FRM_RNE = 3'd0; // nearest, ties to even
    localparam rnd_mode_t FRM_RTZ = 3'd1; // toward zero
    localparam rnd_mode_t FRM_RDN = 3'd2; // toward -inf
    localparam rnd_mode_t FRM_RUP = 3'd3; // toward +inf
    localparam rnd_mode_t FRM_RMM = 3'd4; // nearest, ties away from zero

    localparam fp_exp_t EXP_MAX = 8'd255; // inf / nan exponent

    localparam fp32_t FP_QNAN = 32'h7fc0_0000; // canonical quiet nan

    // status flag positions
    localparam int ST_NV = 3; // invalid operation
    localparam int ST_OF = 2; // overflow
    localparam int ST_UF = 1; // underflow
    localparam int ST_NX = 0; // inexact

endpackage

// ==== verilog/fp_add_top.sv ====
`timescale 1ns/1ns

module fp_add_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,    // one-cycle strobe, no back-pressure
    input  fp_add_pkg::fp32_t     a_i,
    input  fp_add_pkg::fp32_t     b_i,
    input  logic                  sub_i,      // a - b when set
    input  fp_add_pkg::rnd_mode_t rnd_mode_i,
    output logic                  valid_o,    // 3 cycles after valid_i
    output fp_add_pkg::fp32_t     result_o,
    output fp_add_pkg::status_t   status_o
);

    // align -> add/normalize
    logic                  s1_valid;
    logic                  s1_sign;
    logic                  s1_eff_sub;
    fp_add_pkg::fp_exp_t   s1_exp;
    logic [26:0]           s1_man_big;
    logic [26:0]           s1_man_small;
    logic                  s1_special;
    fp_add_pkg::fp32_t     s1_special_val;
    logic                  s1_invalid;
    fp_add_pkg::rnd_mode_t s1_rnd_mode;

    // add/normalize -> round/pack
    logic                  s2_valid;
    fp_add_pkg::fp_abs_t   s2_abs;
    logic                  s2_sign;
    logic [1:0]            s2_rs;
    logic                  s2_eff_sub;
    logic                  s2_ovf;
    logic                  s2_unf;
    logic                  s2_special;
    fp_add_pkg::fp32_t     s2_special_val;
    logic                  s2_invalid;
    fp_add_pkg::rnd_mode_t s2_rnd_mode;

    fp_align i_align (
        .clk_i, .rst_n_i, .valid_i, .a_i, .b_i, .sub_i, .rnd_mode_i,
        .s1_valid_o       (s1_valid),
        .s1_sign_o        (s1_sign),
        .s1_eff_sub_o     (s1_eff_sub),
        .s1_exp_o         (s1_exp),
        .s1_man_big_o     (s1_man_big),
        .s1_man_small_o   (s1_man_small),
        .s1_special_o     (s1_special),
        .s1_special_val_o (s1_special_val),
        .s1_invalid_o     (s1_invalid),
        .s1_rnd_mode_o    (s1_rnd_mode)
    );

    fp_addsub_norm i_norm (
        .clk_i, .rst_n_i,
        .s1_valid_i       (s1_valid),
        .s1_sign_i        (s1_sign),
        .s1_eff_sub_i     (s1_eff_sub),
        .s1_exp_i         (s1_exp),
        .s1_man_big_i     (s1_man_big),
        .s1_man_small_i   (s1_man_small),
        .s1_special_i     (s1_special),
        .s1_special_val_i (s1_special_val),
        .s1_invalid_i     (s1_invalid),
        .s1_rnd_mode_i    (s1_rnd_mode),
        .s2_valid_o       (s2_valid),
        .s2_abs_o         (s2_abs),
        .s2_sign_o        (s2_sign),
        .s2_rs_o          (s2_rs),
        .s2_eff_sub_o     (s2_eff_sub),
        .s2_ovf_o         (s2_ovf),
        .s2_unf_o         (s2_unf),
        .s2_special_o     (s2_special),
        .s2_special_val_o (s2_special_val),
        .s2_invalid_o     (s2_invalid),
        .s2_rnd_mode_o    (s2_rnd_mode)
    );

    fp_round_pack i_round_pack (
        .clk_i, .rst_n_i,
        .s2_valid_i       (s2_valid),
        .s2_abs_i         (s2_abs),
        .s2_sign_i        (s2_sign),
        .s2_rs_i          (s2_rs),
        .s2_eff_sub_i     (s2_eff_sub),
        .s2_ovf_i         (s2_ovf),
        .s2_unf_i         (s2_unf),
        .s2_special_i     (s2_special),
        .s2_special_val_i (s2_special_val),
        .s2_invalid_i     (s2_invalid),
        .s2_rnd_mode_i    (s2_rnd_mode),
        .valid_o, .result_o, .status_o
    );

endmodule

// ==== verilog/fp_addsub_norm.sv ====
`timescale 1ns/1ns

module fp_addsub_norm (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  s1_valid_i,
    input  logic                  s1_sign_i,
    input  logic                  s1_eff_sub_i,
    input  fp_add_pkg::fp_exp_t   s1_exp_i,
    input  logic [26:0]           s1_man_big_i,
    input  logic [26:0]           s1_man_small_i,
    input  logic                  s1_special_i,
    input  fp_add_pkg::fp32_t     s1_special_val_i,
    input  logic                  s1_invalid_i,
    input  fp_add_pkg::rnd_mode_t s1_rnd_mode_i,
    output logic                  s2_valid_o,
    output fp_add_pkg::fp_abs_t   s2_abs_o,       // {exp, fraction} before rounding
    output logic                  s2_sign_o,
    output logic [1:0]            s2_rs_o,        // {round, sticky}
    output logic                  s2_eff_sub_o,
    output logic                  s2_ovf_o,       // exp reached 255
    output logic                  s2_unf_o,       // exp <= 0, nonzero result
    output logic                  s2_special_o,
    output fp_add_pkg::fp32_t     s2_special_val_o,
    output logic                  s2_invalid_o,
    output fp_add_pkg::rnd_mode_t s2_rnd_mode_o
);

    logic [27:0]        sum;       // carry + 27 bits
    logic [4:0]         lz;
    logic [26:0]        shifted;
    logic [23:0]        norm_man;  // 1.fraction
    logic               rbit;
    logic               sbit;
    logic signed [9:0]  exp_n;     // wide enough to go below zero
    logic               res_zero;

    // leading zeros of the 27-bit sum, 27 for all zero
    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] cnt;
        cnt = 5'd27;
        for (int i = 0; i < 27; i++) begin
            if (v[i]) cnt = 5'(26 - i); // highest set bit wins
        end
        return cnt;
    endfunction

    // big >= small in magnitude so the difference never goes negative
    assign sum = s1_eff_sub_i ? ({1'b0, s1_man_big_i} - {1'b0, s1_man_small_i})
                              : ({1'b0, s1_man_big_i} + {1'b0, s1_man_small_i});

    assign lz       = lzc27(sum[26:0]);
    assign shifted  = sum[26:0] << lz;
    assign res_zero = (sum == '0);

    always_comb begin
        if (sum[27]) begin
            // carry out, one step right, the dropped bit joins sticky
            norm_man = sum[27:4];
            rbit     = sum[3];
            sbit     = |sum[2:0];
            exp_n    = $signed({2'b00, s1_exp_i}) + 10'sd1;
        end else begin
            norm_man = shifted[26:3];
            rbit     = shifted[2];
            sbit     = |shifted[1:0];
            exp_n    = $signed({2'b00, s1_exp_i}) - $signed({5'd0, lz});
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s2_valid_o <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_i) begin
            s2_abs_o         <= res_zero ? '0 : {exp_n[7:0], norm_man[22:0]}; // hidden bit drops
            s2_sign_o        <= s1_sign_i;
            s2_rs_o          <= {rbit, sbit};
            s2_eff_sub_o     <= s1_eff_sub_i;
            s2_ovf_o         <= (exp_n >= 10'sd255);
            s2_unf_o         <= (exp_n <= 10'sd0) && !res_zero;
            s2_special_o     <= s1_special_i;
            s2_special_val_o <= s1_special_val_i;
            s2_invalid_o     <= s1_invalid_i;
            s2_rnd_mode_o    <= s1_rnd_mode_i;
        end
    end

endmodule

// ==== verilog/fp_align.sv ====
`timescale 1ns/1ns

module fp_align (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  fp_add_pkg::fp32_t     a_i,
    input  fp_add_pkg::fp32_t     b_i,
    input  logic                  sub_i,            // a - b when set
    input  fp_add_pkg::rnd_mode_t rnd_mode_i,
    output logic                  s1_valid_o,
    output logic                  s1_sign_o,        // sign of the larger operand
    output logic                  s1_eff_sub_o,
    output fp_add_pkg::fp_exp_t   s1_exp_o,         // exponent of the larger operand
    output logic [26:0]           s1_man_big_o,     // {1.fraction, g, r, s}
    output logic [26:0]           s1_man_small_o,   // aligned, sticky folded into bit 0
    output logic                  s1_special_o,
    output fp_add_pkg::fp32_t     s1_special_val_o,
    output logic                  s1_invalid_o,
    output fp_add_pkg::rnd_mode_t s1_rnd_mode_o
);

    logic                sign_b;     // b sign after the subtract flip
    logic                zero_a;
    logic                zero_b;
    logic                inf_a;
    logic                inf_b;
    logic                nan_a;
    logic                nan_b;
    logic                eff_sub;
    logic                inf_inv;    // +inf - inf
    logic [30:0]         mag_a;
    logic [30:0]         mag_b;
    logic                a_big;
    fp_add_pkg::fp_man_t man_a;
    fp_add_pkg::fp_man_t man_b;
    fp_add_pkg::fp_exp_t exp_big;
    fp_add_pkg::fp_exp_t exp_diff;
    logic [4:0]          shamt;
    logic [53:0]         shift_ext;  // aligned bits above, shifted-out bits below
    logic                special;
    fp_add_pkg::fp32_t   special_val;

    // zero exponent covers zero and subnormal, both read as signed zero
    assign zero_a = (a_i[30:23] == '0);
    assign zero_b = (b_i[30:23] == '0);
    assign inf_a  = (a_i[30:23] == fp_add_pkg::EXP_MAX) && (a_i[22:0] == '0);
    assign inf_b  = (b_i[30:23] == fp_add_pkg::EXP_MAX) && (b_i[22:0] == '0);
    assign nan_a  = (a_i[30:23] == fp_add_pkg::EXP_MAX) && (a_i[22:0] != '0);
    assign nan_b  = (b_i[30:23] == fp_add_pkg::EXP_MAX) && (b_i[22:0] != '0);

    assign sign_b  = b_i[31] ^ sub_i;
    assign eff_sub = a_i[31] ^ sign_b;
    assign inf_inv = inf_a && inf_b && eff_sub;

    assign mag_a = zero_a ? '0 : a_i[30:0];
    assign mag_b = zero_b ? '0 : b_i[30:0];
    assign man_a = zero_a ? '0 : {1'b1, a_i[22:0]};
    assign man_b = zero_b ? '0 : {1'b1, b_i[22:0]};

    // larger magnitude goes first, ties keep a
    assign a_big    = (mag_a >= mag_b);
    assign exp_big  = a_big ? mag_a[30:23] : mag_b[30:23];
    assign exp_diff = a_big ? (mag_a[30:23] - mag_b[30:23]) : (mag_b[30:23] - mag_a[30:23]);
    assign shamt    = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0]; // 27 clears it all

    assign shift_ext = {(a_big ? man_b : man_a), 3'b000, 27'd0} >> shamt;

    always_comb begin
        special     = 1'b1;
        special_val = fp_add_pkg::FP_QNAN;
        if (nan_a || nan_b || inf_inv) begin
            special_val = fp_add_pkg::FP_QNAN; // every nan leaves canonical
        end else if (inf_a) begin
            special_val = {a_i[31], fp_add_pkg::EXP_MAX, 23'd0};
        end else if (inf_b) begin
            special_val = {sign_b, fp_add_pkg::EXP_MAX, 23'd0};
        end else begin
            special = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= valid_i;
        end
    end

    // payload only loads with a strobe
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            s1_sign_o        <= a_big ? a_i[31] : sign_b;
            s1_eff_sub_o     <= eff_sub;
            s1_exp_o         <= exp_big;
            s1_man_big_o     <= {(a_big ? man_a : man_b), 3'b000};
            s1_man_small_o   <= {shift_ext[53:28], shift_ext[27] | (|shift_ext[26:0])};
            s1_special_o     <= special;
            s1_special_val_o <= special_val;
            // snan has the quiet bit clear
            s1_invalid_o     <= inf_inv || (nan_a && !a_i[22]) || (nan_b && !b_i[22]);
            s1_rnd_mode_o    <= rnd_mode_i;
        end
    end

endmodule

// ==== verilog/fp_round_pack.sv ====
`timescale 1ns/1ns

module fp_round_pack (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  s2_valid_i,
    input  fp_add_pkg::fp_abs_t   s2_abs_i,
    input  logic                  s2_sign_i,
    input  logic [1:0]            s2_rs_i,
    input  logic                  s2_eff_sub_i,
    input  logic                  s2_ovf_i,
    input  logic                  s2_unf_i,
    input  logic                  s2_special_i,
    input  fp_add_pkg::fp32_t     s2_special_val_i,
    input  logic                  s2_invalid_i,
    input  fp_add_pkg::rnd_mode_t s2_rnd_mode_i,
    output logic                  valid_o,
    output fp_add_pkg::fp32_t     result_o,
    output fp_add_pkg::status_t   status_o
);

    fp_add_pkg::fp_abs_t abs_rnd;
    logic                sign_rnd;
    logic                to_inf;    // mode pushes an overflow out to infinity
    fp_add_pkg::fp32_t   res;
    fp_add_pkg::status_t st;

    fp_rounding #(
        .DAT_WIDTH ($bits(fp_add_pkg::fp_abs_t))
    ) i_rounding (
        .abs_value_i             (s2_abs_i),
        .sign_i                  (s2_sign_i),
        .round_sticky_bits_i     (s2_rs_i),
        .rnd_mode_i              (s2_rnd_mode_i),
        .effective_subtraction_i (s2_eff_sub_i),
        .abs_rounded_o           (abs_rnd),
        .sign_o                  (sign_rnd),
        .exact_zero_o            ()
    );

    assign to_inf = (s2_rnd_mode_i == fp_add_pkg::FRM_RNE) ||
                    (s2_rnd_mode_i == fp_add_pkg::FRM_RMM) ||
                    ((s2_rnd_mode_i == fp_add_pkg::FRM_RUP) && !s2_sign_i) ||
                    ((s2_rnd_mode_i == fp_add_pkg::FRM_RDN) && s2_sign_i);

    always_comb begin
        st = '0;
        if (s2_special_i) begin
            res                   = s2_special_val_i; // nan or signed inf
            st[fp_add_pkg::ST_NV] = s2_invalid_i;
        end else if (s2_ovf_i ||
                     (!s2_unf_i && (abs_rnd[30:23] == fp_add_pkg::EXP_MAX))) begin
            // a tiny result has no real exponent in abs
            res = to_inf ? {s2_sign_i, fp_add_pkg::EXP_MAX, 23'd0}
                         : {s2_sign_i, 8'hfe, 23'h7f_ffff}; // largest finite
            st[fp_add_pkg::ST_OF] = 1'b1;
            st[fp_add_pkg::ST_NX] = 1'b1;
        end else if (s2_unf_i) begin
            res                   = {s2_sign_i, 31'd0}; // flush tiny result
            st[fp_add_pkg::ST_UF] = 1'b1;
            st[fp_add_pkg::ST_NX] = 1'b1;
        end else begin
            res                   = {sign_rnd, abs_rnd};
            st[fp_add_pkg::ST_NX] = |s2_rs_i;
        end
    end

    // outputs hold the last result between strobes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            status_o <= '0;
        end else begin
            valid_o <= s2_valid_i;
            if (s2_valid_i) begin
                result_o <= res;
                status_o <= st;
            end
        end
    end

endmodule

// ==== verilog/fp_rounding.sv ====
`timescale 1ns/1ns

module fp_rounding #(
    parameter int DAT_WIDTH = 31 // magnitude width, sign excluded
) (
    input  logic [DAT_WIDTH-1:0]  abs_value_i,             // magnitude, no sign
    input  logic                  sign_i,
    input  logic [1:0]            round_sticky_bits_i,     // {round, sticky}
    input  fp_add_pkg::rnd_mode_t rnd_mode_i,
    input  logic                  effective_subtraction_i, // zero sign depends on it
    output logic [DAT_WIDTH-1:0]  abs_rounded_o,
    output logic                  sign_o,
    output logic                  exact_zero_o
);

    logic round_up;

    always_comb begin
        case (rnd_mode_i)
            fp_add_pkg::FRM_RNE: begin
                if (round_sticky_bits_i == 2'b10) begin
                    round_up = abs_value_i[0]; // tie, go to the even neighbour
                end else begin
                    round_up = (round_sticky_bits_i == 2'b11); // above half
                end
            end
            fp_add_pkg::FRM_RTZ: round_up = 1'b0;                              // truncate
            fp_add_pkg::FRM_RDN: round_up = (|round_sticky_bits_i) && sign_i;  // away if -
            fp_add_pkg::FRM_RUP: round_up = (|round_sticky_bits_i) && !sign_i; // away if +
            fp_add_pkg::FRM_RMM: round_up = round_sticky_bits_i[1];            // half and above
            default:             round_up = 1'b0;
        endcase
    end

    // mantissa carry walks into the exponent, 254 can step to 255
    assign abs_rounded_o = abs_value_i + DAT_WIDTH'(round_up);

    assign exact_zero_o = (abs_value_i == '0) && (round_sticky_bits_i == 2'b00);

    // x - x gives -0 only when rounding down
    assign sign_o = (exact_zero_o && effective_subtraction_i) ?
                    (rnd_mode_i == fp_add_pkg::FRM_RDN) : sign_i;

endmodule
